/* Bender.yml */
package:
  name: femto_core

export_include_dirs:
  - .

sources:
  - femtoPkg.sv
  - instrDecoder.sv
  - registerFile.sv
  - integerAlu.sv
  - loadStoreUnit.sv
  - femtoCore.sv
  - target: test
    files:
      - femtoCoreTb.sv

/* femtoCore.sv */
/*
 * FemtoRV RV32I core top
 * PC, instruction register, four-state FSM, next-PC select, write-back
 * and the strobe/mask/busy memory bus
 */
`timescale 1ns/100ps
`include "femto_macros.svh"

module femtoCore (
   input  logic            clk,
   input  logic            reset,
   output femtoPkg::word_t memAddr,
   output femtoPkg::word_t memWdata,
   output logic [3:0]      memWmask,
   input  femtoPkg::word_t memRdata,
   output logic            memRstrb,
   input  logic            memRbusy,
   input  logic            memWbusy
);
   import femtoPkg::*;

   // ADDI x0,x0,0 so the reset WAIT_MEM state does no write-back
   localparam word_t NOP_INSTR = {25'd0, `OP_ALUIMM, 2'b11};

   coreState_t state;
   word_t      pc;
   word_t      instr;     // Latched instruction
   word_t      decodeIn;
   word_t      pcPlus4;
   word_t      pcPlusImm;
   word_t      nextPc;
   word_t      writeBackData;
   logic       jumpToImm;
   logic       memIdle;
   logic       readEn;
   logic       writeEn;

   logic       isLoad, isStore, isAluImm, isAluReg, isLui;
   logic       isAuipc, isBranch, isJal, isJalr;
   funct3Hot_t funct3Hot;
   regIdx_t    rs1Id, rs2Id, rdId;
   word_t      immI, immS, immB, immU, immJ;

   word_t      rs1Val, rs2Val;
   word_t      aluOut, aluPlus;
   logic       takeBranch;
   word_t      lsAddr, storeData, loadData;
   logic [3:0] storeMask;

   // Decode the incoming word while waiting so rs1/rs2 indices are ready
   assign decodeIn = (state == WAIT_INSTR) ? memRdata : instr;

   instrDecoder decoder0 (
      .instr(decodeIn), .isLoad(isLoad), .isStore(isStore),
      .isAluImm(isAluImm), .isAluReg(isAluReg), .isLui(isLui),
      .isAuipc(isAuipc), .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
      .funct3Hot(funct3Hot), .rs1Id(rs1Id), .rs2Id(rs2Id), .rdId(rdId),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   registerFile regFile0 (
      .clk(clk), .reset(reset), .readEn(readEn),
      .rs1Id(rs1Id), .rs2Id(rs2Id), .rs1Val(rs1Val), .rs2Val(rs2Val),
      .writeEn(writeEn), .rdId(rdId), .rdData(writeBackData)
   );

   integerAlu alu0 (
      .rs1Val(rs1Val), .rs2Val(rs2Val), .immI(immI),
      .useRs2(isAluReg | isBranch),
      .subtract(instr[30] & instr[5]), // SUB only, not ADDI with imm bit 10
      .arithShift(instr[30]),          // SRA/SRAI
      .funct3Hot(funct3Hot), .aluOut(aluOut), .aluPlus(aluPlus),
      .takeBranch(takeBranch)
   );

   loadStoreUnit lsu0 (
      .rs1Val(rs1Val), .rs2Val(rs2Val), .immI(immI), .immS(immS),
      .isStore(isStore), .funct3Hot(funct3Hot), .memRdata(memRdata),
      .lsAddr(lsAddr), .storeData(storeData), .storeMask(storeMask),
      .loadData(loadData)
   );

   // Target adders
   assign pcPlus4   = pc + 32'd4;
   assign pcPlusImm = pc + (isJal ? immJ : isAuipc ? immU : immB); // JAL, AUIPC, branch
   assign jumpToImm = isJal | (isBranch & takeBranch);

   assign nextPc = isJalr    ? {aluPlus[`WORD_W-1:1], 1'b0} :
                   jumpToImm ? pcPlusImm :
                   pcPlus4;

   assign writeBackData =
      (isLui                 ? immU      : '0) |
      (isAluImm | isAluReg   ? aluOut    : '0) |
      (isAuipc               ? pcPlusImm : '0) |
      (isJal | isJalr        ? pcPlus4   : '0) |
      (isLoad                ? loadData  : '0);

   assign memIdle = !memRbusy && !memWbusy;
   assign readEn  = (state == WAIT_INSTR) && !memRbusy; // Operands load with the instr

   // Loads write back in WAIT_MEM, everything else with a rd in EXECUTE
   assign writeEn =
      ((state == EXECUTE) &&
       (isAluImm | isAluReg | isLui | isAuipc | isJal | isJalr)) ||
      ((state == WAIT_MEM) && isLoad && memIdle);

   // Memory bus
   assign memAddr  = ((state == FETCH_INSTR) || (state == WAIT_INSTR)) ? pc : lsAddr;
   assign memWdata = storeData;
   assign memRstrb = (state == FETCH_INSTR) || ((state == EXECUTE) && isLoad);
   assign memWmask = {4{(state == EXECUTE) && isStore}} & storeMask;

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= WAIT_MEM; // Let any pending write finish first
         pc    <= `RESET_ADDR;
         instr <= NOP_INSTR;
      end else begin
         unique case (state)
            FETCH_INSTR: begin
               state <= WAIT_INSTR;
            end
            WAIT_INSTR: begin
               if (!memRbusy) begin
                  instr <= memRdata;
                  state <= EXECUTE;
               end
            end
            EXECUTE: begin
               pc    <= nextPc;
               state <= (isLoad | isStore) ? WAIT_MEM : FETCH_INSTR;
            end
            WAIT_MEM: begin
               if (memIdle) begin
                  state <= FETCH_INSTR;
               end
            end
            default: begin
               state <= WAIT_MEM; // Recover from an illegal encoding
            end
         endcase
      end
   end

endmodule

/* femtoCoreTb.sv */
/*
 * FemtoRV core testbench
 * Random RV32I program built alongside an ISA model, busy-stretching
 * memory model, fetch trace and store checks
 */
`timescale 1ns/100ps
`include "femto_macros.svh"

module femtoCoreTb;
   import femtoPkg::*;

   logic       clk = 1'b0;
   logic       reset;
   word_t      memAddr;
   word_t      memWdata;
   word_t      memRdata;
   logic [3:0] memWmask;
   logic       memRstrb;
   logic       memRbusy;
   logic       memWbusy;

   integer     seed;
   int         errors;
   int         cycles;
   int         limit;
   int         fetchIdx;
   int         storeIdx;
   int         rdPending;       // Busy cycles left on the read side
   int         wrPending;
   word_t      rdAddr;
   word_t      mem [1024];      // Bus-side memory, word index is addr[11:2]
   word_t      refMem [1024];   // Model copy of data memory
   word_t      regs [8];        // Model x0..x7
   word_t      genPc;           // Next program address
   word_t      expFetch [$];    // Model PC trace
   word_t      expStAddr [$];
   word_t      expStData [$];   // Only the written lanes
   logic [3:0] expStMask [$];

   femtoCore dut0 (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRdata(memRdata), .memRstrb(memRstrb),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   always #20 clk = ~clk; // 40 ns period

   function automatic int rnd(input int n);
      return {$random(seed)} % n;
   endfunction

   function automatic word_t laneBits(input logic [3:0] mask);
      return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
   endfunction

   task automatic checkValue(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // I-type, also R-type with {funct7, rs2} in the immediate field
   function automatic word_t encI(input logic [4:0] op, input int rd, input int f3,
                                  input int rs1, input logic [11:0] imm);
      return {imm, 5'(rs1), 3'(f3), 5'(rd), op, 2'b11};
   endfunction

   function automatic word_t encS(input int f3, input int rs2, input int rs1,
                                  input logic [11:0] imm);
      return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], `OP_STORE, 2'b11};
   endfunction

   function automatic word_t encJ(input int rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), `OP_JAL, 2'b11};
   endfunction

   function automatic word_t aluModel(input int f3, input logic alt,
                                      input word_t a, input word_t b);
      logic signed [31:0] sra;
      sra = $signed(a) >>> b[4:0];
      case (f3)
         0: return alt ? a - b : a + b;
         1: return a << b[4:0];
         2: return word_t'($signed(a) < $signed(b));
         3: return word_t'(a < b);
         4: return a ^ b;
         5: return alt ? sra : a >> b[4:0];  // SRA or SRL
         6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchModel(input int f3, input word_t a, input word_t b);
      case (f3)
         0: return a == b;
         1: return a != b;
         4: return $signed(a) < $signed(b);
         5: return $signed(a) >= $signed(b);
         6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t loadModel(input int f3, input word_t addr);
      word_t shifted;
      shifted = refMem[addr[11:2]] >> (8 * addr[1:0]); // Addressed lane to bit 0
      case (f3)
         0: return {{24{shifted[7]}}, shifted[7:0]};   // LB
         1: return {{16{shifted[15]}}, shifted[15:0]}; // LH
         4: return {24'b0, shifted[7:0]};
         5: return {16'b0, shifted[15:0]};
         default: return shifted;
      endcase
   endfunction

   task automatic emit(input word_t instr, input logic executed);
      mem[genPc[11:2]] = instr;
      if (executed) begin
         expFetch.push_back(genPc);
      end
      genPc += 4;
   endtask

   // ADDI x0 words, jumped over or run as no-ops
   task automatic emitFillers(input int count, input logic executed);
      for (int i = 0; i < count; i++) begin
         emit(encI(`OP_ALUIMM, 0, 0, rnd(8), 12'(rnd(4096))), executed);
      end
   endtask

   task automatic modelStore(input word_t addr, input int f3, input word_t value);
      logic [3:0] mask;
      word_t      data;
      mask = (f3 == 0) ? 4'b0001 << addr[1:0] :
             (f3 == 1) ? 4'b0011 << addr[1:0] : 4'b1111;
      data = (value << (8 * addr[1:0])) & laneBits(mask);
      refMem[addr[11:2]] = (refMem[addr[11:2]] & ~laneBits(mask)) | data;
      expStAddr.push_back(addr);
      expStMask.push_back(mask);
      expStData.push_back(data);
   endtask

   // Result goes to rd, then a SW exposes it on the bus
   task automatic writeReg(input int rd, input word_t value);
      word_t slot;
      slot = 32'h700 + 4 * rd;
      if (rd != 0) begin
         regs[rd] = value;
      end
      emit(encS(2, rd, 0, slot[11:0]), 1'b1);
      modelStore(slot, 2, regs[rd]); // x0 must store zero
   endtask

   task automatic buildProgram();
      int    rd;
      int    rs1;
      int    rs2;
      int    f3;
      int    k;
      word_t imm;
      word_t pc;
      word_t addr;
      logic  alt;
      for (int i = 0; i < 1024; i++) begin
         mem[i]    = (i < 256) ? '0 : $random(seed); // Random data above 0x400
         refMem[i] = mem[i];
      end
      regs  = '{default: '0};
      genPc = `RESET_ADDR;
      repeat (40) begin
         rd   = rnd(8);
         rs1  = rnd(8);
         rs2  = rnd(8);
         f3   = rnd(8);
         k    = rnd(3);            // Words skipped by a jump
         imm  = $random(seed);
         pc   = genPc;
         addr = 32'h400 + rnd(32'h300);
         case (rnd(9))
            0: begin
               if (f3 == 1 || f3 == 5) begin
                  imm[11:5] = {1'b0, imm[10] & (f3 == 5), 5'b0}; // SLLI SRLI SRAI
               end
               emit(encI(`OP_ALUIMM, rd, f3, rs1, imm[11:0]), 1'b1);
               writeReg(rd, aluModel(f3, f3 == 5 && imm[10], regs[rs1],
                                     {{20{imm[11]}}, imm[11:0]}));
            end
            1: begin
               alt = (f3 == 0 || f3 == 5) && rnd(2); // SUB and SRA
               emit(encI(`OP_ALUREG, rd, f3, rs1, {1'b0, alt, 5'b0, 5'(rs2)}), 1'b1);
               writeReg(rd, aluModel(f3, alt, regs[rs1], regs[rs2]));
            end
            2: begin
               emit({imm[31:12], 5'(rd), `OP_LUI, 2'b11}, 1'b1);
               writeReg(rd, {imm[31:12], 12'b0});
            end
            3: begin
               emit({imm[31:12], 5'(rd), `OP_AUIPC, 2'b11}, 1'b1);
               writeReg(rd, pc + {imm[31:12], 12'b0});
            end
            4: begin
               f3 = rnd(5);
               if (f3 > 2) begin
                  f3 = f3 + 1;     // LBU LHU
               end
               addr &= ~word_t'((1 << (f3 & 3)) - 1);
               emit(encI(`OP_LOAD, rd, f3, 0, addr[11:0]), 1'b1);
               writeReg(rd, loadModel(f3, addr));
            end
            5: begin
               f3 = rnd(3);
               addr &= ~word_t'((1 << f3) - 1);
               emit(encS(f3, rs2, 0, addr[11:0]), 1'b1);
               modelStore(addr, f3, regs[rs2]);
            end
            6: begin
               f3 = rnd(6);
               if (f3 > 1) begin
                  f3 = f3 + 2;     // BLT..BGEU
               end
               imm = 4 * (k + 1);
               alt = branchModel(f3, regs[rs1], regs[rs2]);
               emit({imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11],
                     `OP_BRANCH, 2'b11}, 1'b1);
               emitFillers(k, !alt); // Run only when not taken
            end
            7: begin
               emit(encJ(rd, 21'(4 * (k + 1))), 1'b1);
               emitFillers(k, 1'b0);
               writeReg(rd, pc + 4);
            end
            default: begin
               addr = pc + 4 * (k + 1) + rnd(2); // Odd target, bit 0 gets cleared
               emit(encI(`OP_JALR, rd, 0, 0, addr[11:0]), 1'b1);
               emitFillers(k, 1'b0);
               writeReg(rd, pc + 4);
            end
         endcase
      end
      emit(encJ(0, 21'd0), 1'b1); // Self loop ends the program
   endtask

   // Bus monitor and memory model, all on the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         checkValue({memRstrb, memWmask}, '0, "strobe and mask in reset");
      end else begin
         checkValue((memRstrb || memWmask != 0) && (memRbusy || memWbusy), '0,
                    "access issued while busy");
         if (memRstrb && memAddr < 32'h400 && fetchIdx < expFetch.size()) begin
            checkValue(memAddr, expFetch[fetchIdx], "fetch address");
            fetchIdx++;
         end
         if (memWmask != 0) begin
            if (storeIdx < expStAddr.size()) begin
               checkValue(memAddr, expStAddr[storeIdx], "store address");
               checkValue(memWmask, expStMask[storeIdx], "store mask");
               checkValue(memWdata & laneBits(memWmask), expStData[storeIdx], "store data");
               storeIdx++;
            end else begin
               $display("Unexpected store at %0t ns to address %h", $time, memAddr);
               errors++;
            end
            mem[memAddr[11:2]] = (mem[memAddr[11:2]] & ~laneBits(memWmask)) |
                                 (memWdata & laneBits(memWmask));
         end
         if (rdPending > 0) begin
            rdPending--;
         end
         if (wrPending > 0) begin
            wrPending--;
         end
         if (memRstrb) begin
            rdAddr    = memAddr;
            rdPending = rnd(4);    // 0 to 2 busy cycles seen by the core
         end
         if (memWmask != 0) begin
            wrPending = rnd(4);
         end
         memRbusy <= (rdPending != 0);
         memWbusy <= (wrPending != 0);
         memRdata <= mem[rdAddr[11:2]];
      end
   end

   initial begin
      seed      = 32'h1b48;
      reset     = 1'b0;
      memRdata  = '0;
      memRbusy  = 1'b0;
      memWbusy  = 1'b0;
      errors    = 0;
      cycles    = 0;
      fetchIdx  = 0;
      storeIdx  = 0;
      rdPending = 0;
      wrPending = 0;
      rdAddr    = '0;
      buildProgram();
      limit = expFetch.size() * (4 + 2 + 2) * 2; // Slowest instruction, twice over
      repeat (5) @(negedge clk);
      reset = 1'b1;
      while ((fetchIdx < expFetch.size() || storeIdx < expStAddr.size()) &&
             cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      @(posedge clk);
      if (fetchIdx < expFetch.size() || storeIdx < expStAddr.size()) begin
         $display("Timeout after %0d cycles, the core did not reach the end of the program",
                  cycles);
         errors++;
      end
      $display("Errors %0d, fetches checked %0d, stores checked %0d",
               errors, fetchIdx, storeIdx);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* femtoPkg.sv */
/*
 * FemtoRV shared types
 * Word, register index, one-hot funct3 and the core FSM states
 */
`include "femto_macros.svh"

package femtoPkg;

   typedef logic [`WORD_W-1:0] word_t;              // Data or address word

   typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;  // Register index

   // funct3 decoded one-hot, bit n set when funct3 == n
   typedef logic [7:0] funct3Hot_t;

   // Top-level FSM
   typedef enum logic [3:0] {
      FETCH_INSTR = 4'b0001, // Strobe the PC onto the bus
      WAIT_INSTR  = 4'b0010, // Wait for the instruction word
      EXECUTE     = 4'b0100, // One cycle of real work
      WAIT_MEM    = 4'b1000  // Wait for load/store to drain
   } coreState_t;

endpackage

/* femto_macros.svh */
/*
 * FemtoRV sizes, reset address and RV32I opcode field values
 * Shared by the package, the RTL and the testbench assembler
 */
`ifndef FEMTO_MACROS_SVH
`define FEMTO_MACROS_SVH

`define WORD_W     32            // Data and address width
`define NUM_REGS   32            // Integer registers x0..x31
`define RESET_ADDR 32'h0000_0000 // First fetch address

// Opcode groups as seen in instr[6:2]
`define OP_LOAD    5'b00000 // rd <- mem[rs1+immI]
`define OP_ALUIMM  5'b00100 // rd <- rs1 op immI
`define OP_AUIPC   5'b00101 // rd <- PC + immU
`define OP_STORE   5'b01000 // mem[rs1+immS] <- rs2
`define OP_ALUREG  5'b01100 // rd <- rs1 op rs2
`define OP_LUI     5'b01101 // rd <- immU
`define OP_BRANCH  5'b11000 // PC <- PC + immB when taken
`define OP_JALR    5'b11001 // rd <- PC+4 and PC <- rs1+immI
`define OP_JAL     5'b11011 // rd <- PC+4 and PC <- PC+immJ

`endif

/* instrDecoder.sv */
/*
 * RV32I instruction decoder
 * Opcode class flags, register indices, one-hot funct3 and the five
 * sign-extended immediate formats
 */
`timescale 1ns/100ps
`include "femto_macros.svh"

module instrDecoder (
   input  femtoPkg::word_t      instr,
   output logic                 isLoad,
   output logic                 isStore,
   output logic                 isAluImm,
   output logic                 isAluReg,
   output logic                 isLui,
   output logic                 isAuipc,
   output logic                 isBranch,
   output logic                 isJal,
   output logic                 isJalr,
   output femtoPkg::funct3Hot_t funct3Hot,
   output femtoPkg::regIdx_t    rs1Id,
   output femtoPkg::regIdx_t    rs2Id,
   output femtoPkg::regIdx_t    rdId,
   output femtoPkg::word_t      immI,
   output femtoPkg::word_t      immS,
   output femtoPkg::word_t      immB,
   output femtoPkg::word_t      immU,
   output femtoPkg::word_t      immJ
);
   import femtoPkg::*;

   logic [4:0] opcode;

   assign opcode = instr[6:2]; // Bits 1:0 are always 11 in RV32I

   // Opcode classes, SYSTEM and unknown groups raise none of them
   assign isLoad   = (opcode == `OP_LOAD);
   assign isAluImm = (opcode == `OP_ALUIMM);
   assign isAuipc  = (opcode == `OP_AUIPC);
   assign isStore  = (opcode == `OP_STORE);
   assign isAluReg = (opcode == `OP_ALUREG);
   assign isLui    = (opcode == `OP_LUI);
   assign isBranch = (opcode == `OP_BRANCH);
   assign isJalr   = (opcode == `OP_JALR);
   assign isJal    = (opcode == `OP_JAL);

   // One-hot funct3 keeps the ALU and LSU selects to single bits
   assign funct3Hot = funct3Hot_t'(8'b0000_0001 << instr[14:12]);

   assign rs1Id = instr[19:15];
   assign rs2Id = instr[24:20];
   assign rdId  = instr[11:7];

   // Immediates, all sign-extended from instr[31]
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};                        // Upper 20 bits
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

/* integerAlu.sv */
/*
 * RV32I integer ALU
 * Adder, shared 33-bit subtract for SUB and compares, one right shifter
 * reused for left shifts by bit reversal, logic ops and branch predicate
 */
`timescale 1ns/100ps
`include "femto_macros.svh"

module integerAlu (
   input  femtoPkg::word_t      rs1Val,
   input  femtoPkg::word_t      rs2Val,
   input  femtoPkg::word_t      immI,
   input  logic                 useRs2,
   input  logic                 subtract,
   input  logic                 arithShift,
   input  femtoPkg::funct3Hot_t funct3Hot,
   output femtoPkg::word_t      aluOut,
   output femtoPkg::word_t      aluPlus,
   output logic                 takeBranch
);
   import femtoPkg::*;

   word_t       aluIn2;
   logic [32:0] aluMinus;
   logic        lessSigned;
   logic        lessUnsigned;
   logic        isEqual;
   word_t       shiftIn;
   logic [32:0] shiftExt;
   word_t       shiftOut;
   word_t       leftShift;

   function automatic word_t reverseBits(input word_t value);
      word_t result;
      for (int i = 0; i < `WORD_W; i++) begin
         result[i] = value[`WORD_W-1-i];
      end
      return result;
   endfunction

   // rs2 for ALU-reg and branches, immI for ALU-imm and JALR
   assign aluIn2  = useRs2 ? rs2Val : immI;
   assign aluPlus = rs1Val + aluIn2; // Also the JALR target

   // Bit 32 is the borrow, set when rs1 < aluIn2 unsigned
   assign aluMinus     = {1'b1, ~aluIn2} + {1'b0, rs1Val} + 33'd1;
   assign lessUnsigned = aluMinus[32];
   assign lessSigned   = (rs1Val[31] ^ aluIn2[31]) ? rs1Val[31] : aluMinus[32];
   assign isEqual      = (aluMinus[31:0] == '0);

   // Left shift runs through the right shifter on reversed bits
   assign shiftIn   = funct3Hot[1] ? reverseBits(rs1Val) : rs1Val;
   assign shiftExt  = $signed({arithShift & rs1Val[31], shiftIn}) >>> aluIn2[4:0];
   assign shiftOut  = shiftExt[31:0];       // Extension bit dropped
   assign leftShift = reverseBits(shiftOut);

   // Result select by funct3
   assign aluOut =
      (funct3Hot[0] ? (subtract ? aluMinus[31:0] : aluPlus) : '0) | // ADD/SUB
      (funct3Hot[1] ? leftShift                              : '0) | // SLL
      (funct3Hot[2] ? {31'b0, lessSigned}                    : '0) | // SLT
      (funct3Hot[3] ? {31'b0, lessUnsigned}                  : '0) | // SLTU
      (funct3Hot[4] ? rs1Val ^ aluIn2                        : '0) | // XOR
      (funct3Hot[5] ? shiftOut                               : '0) | // SRL/SRA
      (funct3Hot[6] ? rs1Val | aluIn2                        : '0) | // OR
      (funct3Hot[7] ? rs1Val & aluIn2                        : '0);  // AND

   // Branch predicate, funct3 2 and 3 are not branches
   assign takeBranch =
      (funct3Hot[0] &  isEqual)      | // BEQ
      (funct3Hot[1] & ~isEqual)      | // BNE
      (funct3Hot[4] &  lessSigned)   | // BLT
      (funct3Hot[5] & ~lessSigned)   | // BGE
      (funct3Hot[6] &  lessUnsigned) | // BLTU
      (funct3Hot[7] & ~lessUnsigned);  // BGEU

endmodule

/* loadStoreUnit.sv */
/*
 * Load/store unit
 * Address adder, store lane steering and mask, load lane extraction
 * with sign or zero extension
 */
`timescale 1ns/100ps
`include "femto_macros.svh"

module loadStoreUnit (
   input  femtoPkg::word_t      rs1Val,
   input  femtoPkg::word_t      rs2Val,
   input  femtoPkg::word_t      immI,
   input  femtoPkg::word_t      immS,
   input  logic                 isStore,
   input  femtoPkg::funct3Hot_t funct3Hot,
   input  femtoPkg::word_t      memRdata,
   output femtoPkg::word_t      lsAddr,
   output femtoPkg::word_t      storeData,
   output logic [3:0]           storeMask,
   output femtoPkg::word_t      loadData
);
   import femtoPkg::*;

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign lsAddr = rs1Val + (isStore ? immS : immI);

   assign byteAccess = funct3Hot[0] | funct3Hot[4]; // LB LBU SB
   assign halfAccess = funct3Hot[1] | funct3Hot[5]; // LH LHU SH

   // Bytes replicated so the addressed lane always carries them
   assign storeData[7:0]   = rs2Val[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2Val[7:0] : rs2Val[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2Val[7:0] : rs2Val[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2Val[7:0] :
                             lsAddr[1] ? rs2Val[15:8] : rs2Val[31:24];

   // One lane for bytes, two for halfwords, all four for words
   assign storeMask = byteAccess ? (4'b0001 << lsAddr[1:0]) :
                      halfAccess ? (lsAddr[1] ? 4'b1100 : 4'b0011) :
                      4'b1111;

   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3 bit 2 set means unsigned load
   assign loadSign = ~(|funct3Hot[7:4]) & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{(`WORD_W-8){loadSign}}, loadByte} :
                     halfAccess ? {{(`WORD_W-16){loadSign}}, loadHalf} :
                     memRdata; // Full word

endmodule

/* registerFile.sv */
/*
 * Integer register file
 * Two registered read ports loaded on readEn, one write port, x0 stays zero
 */
`timescale 1ns/100ps
`include "femto_macros.svh"

module registerFile (
   input  logic              clk,
   input  logic              reset,
   input  logic              readEn,
   input  femtoPkg::regIdx_t rs1Id,
   input  femtoPkg::regIdx_t rs2Id,
   output femtoPkg::word_t   rs1Val,
   output femtoPkg::word_t   rs2Val,
   input  logic              writeEn,
   input  femtoPkg::regIdx_t rdId,
   input  femtoPkg::word_t   rdData
);
   import femtoPkg::*;

   word_t regs [`NUM_REGS];

   // Write port, writes to x0 are dropped
   always_ff @(posedge clk) begin
      if (!reset) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && (rdId != '0)) begin
         regs[rdId] <= rdData;
      end
   end

   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1Val <= regs[rs1Id]; // Operands held for the rest of the instruction
         rs2Val <= regs[rs2Id];
      end
   end

endmodule

/* vlog.f */
+incdir+.
femtoPkg.sv
instrDecoder.sv
registerFile.sv
integerAlu.sv
loadStoreUnit.sv
femtoCore.sv
femtoCoreTb.sv
